// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rvga_core_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
PASS_MSG  := TEST RESULT: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST)) common/rvga_consts.svh

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
+incdir+common
common/rvga_pkg.sv
rtl/regfile.sv
rtl/pc_counter.sv
rtl/pipe_ctrl.sv
decode/decode_stage.sv
execute/exec_stage.sv
rtl/rvga_core.sv
verification/tb_clkgen.sv
verification/rvga_core_tb.sv

// ==== common/rvga_consts.svh ====
`ifndef RVGA_CONSTS_SVH
`define RVGA_CONSTS_SVH

// Machine word width in bits.
`define RVGA_XLEN 32

// Architectural register count and the index width that addresses it.
`define RVGA_NREGS 32
`define RVGA_REGW 5

// Program counter given to the first accepted instruction.
`define RVGA_RESET_PC 32'h0000_1000

`endif

// ==== common/rvga_pkg.sv ====
`default_nettype none

package rvga_pkg;

  typedef enum logic [6:0] {
    e_rvga_opcode_lui   = 7'b0110111,
    e_rvga_opcode_auipc = 7'b0010111,
    e_rvga_opcode_imm   = 7'b0010011,
    e_rvga_opcode_br    = 7'b1100011
  } rvga_opcode_e;

  typedef enum logic [2:0] {
    e_rvga_inst_type_i,
    e_rvga_inst_type_s,
    e_rvga_inst_type_b,
    e_rvga_inst_type_u,
    e_rvga_inst_type_j,
    e_rvga_inst_type_e
  } rvga_inst_type_e;

  typedef enum logic [2:0] {
    e_rvga_artop_addsub = 3'b000,
    e_rvga_artop_sll    = 3'b001,
    e_rvga_artop_slt    = 3'b010,
    e_rvga_artop_sltu   = 3'b011,
    e_rvga_artop_xor    = 3'b100,
    e_rvga_artop_srx    = 3'b101,
    e_rvga_artop_or     = 3'b110,
    e_rvga_artop_and    = 3'b111
  } rvga_artop_e;

  typedef enum logic [1:0] {
    e_pipe_empty = 2'b00,
    e_pipe_dec   = 2'b01,
    e_pipe_exe   = 2'b10,
    e_pipe_full  = 2'b11
  } pipe_state_e;

endpackage : rvga_pkg

`default_nettype wire

// ==== decode/decode_stage.sv ====
`default_nettype none

`include "rvga_consts.svh"

module decode_stage (
  input  wire logic                  clk,
  input  wire logic                  rst_n_i,
  input  wire logic                  load_i,
  input  wire logic [`RVGA_XLEN-1:0] pc_i,
  input  wire logic [`RVGA_XLEN-1:0] instr_i,
  output logic [`RVGA_XLEN-1:0]      pc_o,
  output logic [`RVGA_REGW-1:0]      rs1_o,
  output logic [`RVGA_REGW-1:0]      rd_o,
  output logic [`RVGA_XLEN-1:0]      imm_o,
  output rvga_pkg::rvga_artop_e      artop_o,
  output logic                       alt_art_o,
  output logic                       imm_passthrough_o,
  output logic                       rs1_pc_sel_o,
  output logic                       rd_w_v_o,
  output logic                       uses_rs1_o
);

  import rvga_pkg::*;

  rvga_opcode_e            opcode;
  rvga_inst_type_e         inst_type;
  rvga_artop_e             artop;
  logic [`RVGA_REGW-1:0]   rs1;
  logic [`RVGA_REGW-1:0]   rd;
  logic [`RVGA_XLEN-1:0]   imm;
  logic                    alt_art;
  logic                    imm_passthrough;
  logic                    rs1_pc_sel;
  logic                    rd_w_v;
  logic                    uses_rs1;

  always_comb begin
    rs1    = instr_i[19:15];
    rd     = instr_i[11:7];
    opcode = rvga_opcode_e'(instr_i[6:0]);
    artop  = e_rvga_artop_addsub;

    alt_art         = 1'b0;
    imm_passthrough = 1'b0;
    rs1_pc_sel      = 1'b0;
    rd_w_v          = 1'b0;
    uses_rs1        = 1'b0;

    case (opcode)
      e_rvga_opcode_lui: begin
        inst_type       = e_rvga_inst_type_u;
        rd_w_v          = 1'b1;
        imm_passthrough = 1'b1;
      end
      e_rvga_opcode_auipc: begin
        inst_type  = e_rvga_inst_type_u;
        rd_w_v     = 1'b1;
        rs1_pc_sel = 1'b1; // The adder takes the PC in place of rs1.
      end
      e_rvga_opcode_imm: begin
        inst_type = e_rvga_inst_type_i;
        artop     = rvga_artop_e'(instr_i[14:12]);
        rd_w_v    = 1'b1;
        uses_rs1  = 1'b1;
        if (artop == e_rvga_artop_srx) begin
          alt_art = instr_i[30]; // Bit 30 picks SRAI over SRLI.
        end
      end
      e_rvga_opcode_br: inst_type = e_rvga_inst_type_b; // Not executed, no write.
      default: inst_type = e_rvga_inst_type_e;
    endcase

    case (inst_type)
      e_rvga_inst_type_i: begin
        if ((artop == e_rvga_artop_sll) || (artop == e_rvga_artop_srx)) begin
          imm = {27'b0, instr_i[24:20]};
        end else begin
          imm = {{20{instr_i[31]}}, instr_i[31:20]};
        end
      end
      e_rvga_inst_type_b: imm = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                                 instr_i[11:8], 1'b0};
      e_rvga_inst_type_u: imm = {instr_i[31:12], 12'b0};
      default:            imm = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      artop_o           <= e_rvga_artop_addsub;
      alt_art_o         <= 1'b0;
      imm_passthrough_o <= 1'b0;
      rs1_pc_sel_o      <= 1'b0;
      rd_w_v_o          <= 1'b0;
      uses_rs1_o        <= 1'b0;
    end else if (load_i) begin
      artop_o           <= artop;
      alt_art_o         <= alt_art;
      imm_passthrough_o <= imm_passthrough;
      rs1_pc_sel_o      <= rs1_pc_sel;
      rd_w_v_o          <= rd_w_v;
      uses_rs1_o        <= uses_rs1;
    end
  end

  always_ff @(posedge clk) begin
    if (load_i) begin
      pc_o  <= pc_i;
      rs1_o <= rs1;
      rd_o  <= rd;
      imm_o <= imm;
    end
  end

endmodule : decode_stage

`default_nettype wire

// ==== execute/exec_stage.sv ====
`default_nettype none

`include "rvga_consts.svh"

module exec_stage (
  input  wire logic                  clk,
  input  wire logic                  rst_n_i,
  input  wire logic                  load_i,
  input  wire logic [`RVGA_XLEN-1:0] pc_i,
  input  wire logic [`RVGA_REGW-1:0] rs1_i,
  input  wire logic [`RVGA_REGW-1:0] rd_i,
  input  wire logic [`RVGA_XLEN-1:0] imm_i,
  input  rvga_pkg::rvga_artop_e      artop_i,
  input  wire logic                  alt_art_i,
  input  wire logic                  imm_passthrough_i,
  input  wire logic                  rs1_pc_sel_i,
  input  wire logic                  rd_w_v_i,
  input  wire logic                  uses_rs1_i,
  input  wire logic [`RVGA_XLEN-1:0] rs1_data_i,
  output logic [`RVGA_REGW-1:0]      rs1_addr_o,
  output logic [`RVGA_REGW-1:0]      res_rd_o,
  output logic [`RVGA_XLEN-1:0]      res_data_o,
  output logic                       res_w_v_o
);

  import rvga_pkg::*;

  logic [`RVGA_XLEN-1:0] op_a;
  logic [`RVGA_XLEN-1:0] result;
  logic [4:0]            shamt;

  assign rs1_addr_o = rs1_i; // Decoded index goes straight to the read port.
  assign shamt      = imm_i[4:0];

  always_comb begin
    if (rs1_pc_sel_i) begin
      op_a = pc_i;
    end else if (uses_rs1_i) begin
      op_a = rs1_data_i;
    end else begin
      op_a = '0;
    end

    if (imm_passthrough_i) begin
      result = imm_i;
    end else begin
      case (artop_i)
        e_rvga_artop_addsub: result = op_a + imm_i;
        e_rvga_artop_sll:    result = op_a << shamt;
        e_rvga_artop_slt:    result = {31'b0, $signed(op_a) < $signed(imm_i)};
        e_rvga_artop_sltu:   result = {31'b0, op_a < imm_i};
        e_rvga_artop_xor:    result = op_a ^ imm_i;
        e_rvga_artop_srx: begin
          if (alt_art_i) begin
            result = $unsigned($signed(op_a) >>> shamt);
          end else begin
            result = op_a >> shamt;
          end
        end
        e_rvga_artop_or:     result = op_a | imm_i;
        default:             result = op_a & imm_i;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      res_w_v_o <= 1'b0;
    end else if (load_i) begin
      res_w_v_o <= rd_w_v_i;
    end
  end

  always_ff @(posedge clk) begin
    if (load_i) begin
      res_rd_o   <= rd_i;
      res_data_o <= result;
    end
  end

endmodule : exec_stage

`default_nettype wire

// ==== rtl/pc_counter.sv ====
`default_nettype none

`include "rvga_consts.svh"

module pc_counter (
  input  wire logic             clk,
  input  wire logic             rst_n_i,
  input  wire logic             advance_i,
  output logic [`RVGA_XLEN-1:0] pc_o,
  output logic [31:0]           insn_count_o
);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pc_o         <= `RVGA_RESET_PC;
      insn_count_o <= '0;
    end else if (advance_i) begin
      pc_o         <= pc_o + `RVGA_XLEN'(4); // Every instruction is one word.
      insn_count_o <= insn_count_o + 32'd1;
    end
  end

endmodule : pc_counter

`default_nettype wire

// ==== rtl/pipe_ctrl.sv ====
`default_nettype none

`include "rvga_consts.svh"

module pipe_ctrl (
  input  wire logic                  clk,
  input  wire logic                  rst_n_i,
  input  wire logic                  instr_valid_i,
  input  wire logic                  wb_ready_i,
  input  wire logic [`RVGA_REGW-1:0] dec_rs1_i,
  input  wire logic                  dec_uses_rs1_i,
  input  wire logic [`RVGA_REGW-1:0] exe_rd_i,
  input  wire logic                  exe_w_v_i,
  output logic                       instr_ready_o,
  output logic                       dec_load_o,
  output logic                       exe_load_o,
  output logic                       wb_valid_o
);

  import rvga_pkg::*;

  pipe_state_e state;
  pipe_state_e state_next;
  logic        dec_occ;
  logic        exe_occ;
  logic        exe_drain;
  logic        hazard;
  logic        dec_occ_next;
  logic        exe_occ_next;

  assign dec_occ = (state == e_pipe_dec) || (state == e_pipe_full);
  assign exe_occ = (state == e_pipe_exe) || (state == e_pipe_full);

  assign wb_valid_o = exe_occ && exe_w_v_i;

  // A non-writing instruction leaves after one cycle on its own.
  assign exe_drain = exe_occ && (!exe_w_v_i || wb_ready_i);

  // Held until the exe slot has written, even in the transfer cycle itself.
  assign hazard = dec_occ && dec_uses_rs1_i && exe_occ && exe_w_v_i &&
                  (exe_rd_i != '0) && (exe_rd_i == dec_rs1_i);

  assign exe_load_o    = dec_occ && (!exe_occ || exe_drain) && !hazard;
  assign instr_ready_o = !dec_occ || exe_load_o;
  assign dec_load_o    = instr_valid_i && instr_ready_o;

  assign dec_occ_next = dec_load_o || (dec_occ && !exe_load_o);
  assign exe_occ_next = exe_load_o || (exe_occ && !exe_drain);

  always_comb begin
    case ({exe_occ_next, dec_occ_next})
      2'b00:   state_next = e_pipe_empty;
      2'b01:   state_next = e_pipe_dec;
      2'b10:   state_next = e_pipe_exe;
      default: state_next = e_pipe_full;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state <= e_pipe_empty;
    end else begin
      state <= state_next;
    end
  end

endmodule : pipe_ctrl

`default_nettype wire

// ==== rtl/regfile.sv ====
`default_nettype none

`include "rvga_consts.svh"

module regfile (
  input  wire logic                  clk,
  input  wire logic                  rst_n_i,
  input  wire logic                  we_i,
  input  wire logic [`RVGA_REGW-1:0] waddr_i,
  input  wire logic [`RVGA_XLEN-1:0] wdata_i,
  input  wire logic [`RVGA_REGW-1:0] raddr_i,
  output logic [`RVGA_XLEN-1:0]      rdata_o
);

  logic [`RVGA_XLEN-1:0] regs [`RVGA_NREGS];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `RVGA_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i; // x0 is never written.
    end
  end

  // A same-cycle write is not bypassed, so the old value is read.
  always_comb begin
    if (raddr_i == '0) begin
      rdata_o = '0;
    end else begin
      rdata_o = regs[raddr_i];
    end
  end

endmodule : regfile

`default_nettype wire

// ==== rtl/rvga_core.sv ====
`default_nettype none

`include "rvga_consts.svh"

module rvga_core (
  input  wire logic                  clk,
  input  wire logic                  rst_n_i,
  input  wire logic                  instr_valid_i,
  output logic                       instr_ready_o,
  input  wire logic [`RVGA_XLEN-1:0] instr_i,
  output logic                       wb_valid_o,
  input  wire logic                  wb_ready_i,
  output logic [`RVGA_REGW-1:0]      wb_rd_o,
  output logic [`RVGA_XLEN-1:0]      wb_data_o,
  output logic [31:0]                insn_count_o
);

  import rvga_pkg::*;

  logic                  dec_load;
  logic                  exe_load;
  logic [`RVGA_XLEN-1:0] fetch_pc;
  logic [`RVGA_XLEN-1:0] dec_pc;
  logic [`RVGA_REGW-1:0] dec_rs1;
  logic [`RVGA_REGW-1:0] dec_rd;
  logic [`RVGA_XLEN-1:0] dec_imm;
  rvga_artop_e           dec_artop;
  logic                  dec_alt_art;
  logic                  dec_imm_passthrough;
  logic                  dec_rs1_pc_sel;
  logic                  dec_rd_w_v;
  logic                  dec_uses_rs1;
  logic [`RVGA_REGW-1:0] rs1_addr;
  logic [`RVGA_XLEN-1:0] rs1_data;
  logic [`RVGA_REGW-1:0] exe_rd;
  logic [`RVGA_XLEN-1:0] exe_data;
  logic                  exe_w_v;
  logic                  wb_fire;

  assign wb_fire   = wb_valid_o && wb_ready_i; // The register write happens here.
  assign wb_rd_o   = exe_rd;
  assign wb_data_o = exe_data;

  pc_counter u_pc_counter (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .advance_i    (dec_load),
    .pc_o         (fetch_pc),
    .insn_count_o (insn_count_o)
  );

  pipe_ctrl u_pipe_ctrl (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .instr_valid_i  (instr_valid_i),
    .wb_ready_i     (wb_ready_i),
    .dec_rs1_i      (dec_rs1),
    .dec_uses_rs1_i (dec_uses_rs1),
    .exe_rd_i       (exe_rd),
    .exe_w_v_i      (exe_w_v),
    .instr_ready_o  (instr_ready_o),
    .dec_load_o     (dec_load),
    .exe_load_o     (exe_load),
    .wb_valid_o     (wb_valid_o)
  );

  decode_stage u_decode_stage (
    .clk               (clk),
    .rst_n_i           (rst_n_i),
    .load_i            (dec_load),
    .pc_i              (fetch_pc),
    .instr_i           (instr_i),
    .pc_o              (dec_pc),
    .rs1_o             (dec_rs1),
    .rd_o              (dec_rd),
    .imm_o             (dec_imm),
    .artop_o           (dec_artop),
    .alt_art_o         (dec_alt_art),
    .imm_passthrough_o (dec_imm_passthrough),
    .rs1_pc_sel_o      (dec_rs1_pc_sel),
    .rd_w_v_o          (dec_rd_w_v),
    .uses_rs1_o        (dec_uses_rs1)
  );

  exec_stage u_exec_stage (
    .clk               (clk),
    .rst_n_i           (rst_n_i),
    .load_i            (exe_load),
    .pc_i              (dec_pc),
    .rs1_i             (dec_rs1),
    .rd_i              (dec_rd),
    .imm_i             (dec_imm),
    .artop_i           (dec_artop),
    .alt_art_i         (dec_alt_art),
    .imm_passthrough_i (dec_imm_passthrough),
    .rs1_pc_sel_i      (dec_rs1_pc_sel),
    .rd_w_v_i          (dec_rd_w_v),
    .uses_rs1_i        (dec_uses_rs1),
    .rs1_data_i        (rs1_data),
    .rs1_addr_o        (rs1_addr),
    .res_rd_o          (exe_rd),
    .res_data_o        (exe_data),
    .res_w_v_o         (exe_w_v)
  );

  regfile u_regfile (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .we_i    (wb_fire),
    .waddr_i (exe_rd),
    .wdata_i (exe_data),
    .raddr_i (rs1_addr),
    .rdata_o (rs1_data)
  );

endmodule : rvga_core

`default_nettype wire

// ==== verification/rvga_core_tb.sv ====
`default_nettype none

`include "rvga_consts.svh"

module rvga_core_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned WAIT_LIMIT = 400;
  localparam logic [6:0] OPC_LUI   = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC = 7'b0010111;
  localparam logic [6:0] OPC_IMM   = 7'b0010011;

  logic                  clk;
  logic                  rst_n;
  logic                  instr_valid;
  logic                  instr_ready;
  logic [`RVGA_XLEN-1:0] instr;
  logic                  wb_valid;
  logic                  wb_ready;
  logic [`RVGA_REGW-1:0] wb_rd;
  logic [`RVGA_XLEN-1:0] wb_data;
  logic [31:0]           insn_count;

  logic                  ready_random = 1'b0;
  int                    errors = 0;
  int                    timeouts = 0;
  int unsigned           accepted = 0;
  logic [`RVGA_XLEN-1:0] model_pc = `RVGA_RESET_PC;
  logic [`RVGA_XLEN-1:0] model_regs [`RVGA_NREGS];
  logic [36:0]           exp_q [$]; // {rd, data} in program order.

  tb_clkgen u_clkgen (.clk(clk), .rst_n_o(rst_n));

  rvga_core uut (
    .clk           (clk),
    .rst_n_i       (rst_n),
    .instr_valid_i (instr_valid),
    .instr_ready_o (instr_ready),
    .instr_i       (instr),
    .wb_valid_o    (wb_valid),
    .wb_ready_i    (wb_ready),
    .wb_rd_o       (wb_rd),
    .wb_data_o     (wb_data),
    .insn_count_o  (insn_count)
  );

  wb_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
      (wb_valid && !wb_ready) |=> (wb_valid && $stable(wb_rd) && $stable(wb_data)))
    else begin
      errors++;
      $display("writeback valid or data changed while stalled at %0t", $time);
    end

  reset_valid_a: assert property (@(posedge clk) $rose(rst_n) |-> !wb_valid)
    else begin
      errors++;
      $display("mismatch at %0t: wb_valid_o got %b expected 0 after reset", $time,
               $sampled(wb_valid));
    end

  reset_ready_a: assert property (@(posedge clk) $rose(rst_n) |-> instr_ready)
    else begin
      errors++;
      $display("mismatch at %0t: instr_ready_o got %b expected 1 after reset", $time,
               $sampled(instr_ready));
    end

  reset_count_a: assert property (@(posedge clk) $rose(rst_n) |-> (insn_count == 32'd0))
    else begin
      errors++;
      $display("mismatch at %0t: insn_count_o got %0d expected 0 after reset", $time,
               $sampled(insn_count));
    end

  function automatic logic [31:0] make_upper(input logic [6:0] opc, input logic [4:0] rd,
                                             input logic [31:0] rnd);
    return {rnd[31:12], rd, opc};
  endfunction

  function automatic logic [31:0] make_opimm(input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [31:0] rnd,
                                             input logic alt);
    logic [11:0] imm12;
    imm12 = rnd[11:0];
    if ((f3 == 3'd1) || (f3 == 3'd5)) begin
      imm12 = {1'b0, (f3 == 3'd5) && alt, 5'b0, rnd[4:0]}; // Shifts keep funct7 legal.
    end
    return {imm12, rs1, f3, rd, OPC_IMM};
  endfunction

  function automatic logic [31:0] make_unsupported(input logic [31:0] rnd);
    logic [6:0] opcs [5];
    opcs = '{7'b0110011, 7'b1100011, 7'b0000011, 7'b1101111, 7'b0100011};
    return {rnd[31:7], opcs[rnd % 5]};
  endfunction

  function automatic logic [31:0] random_instr();
    int unsigned kind;
    kind = $urandom_range(0, 9);
    if (kind == 0) return make_upper(OPC_LUI, 5'($urandom), $urandom);
    if (kind == 1) return make_upper(OPC_AUIPC, 5'($urandom), $urandom);
    if (kind == 2) return make_unsupported($urandom);
    return make_opimm(3'($urandom), 5'($urandom), 5'($urandom), $urandom, 1'($urandom));
  endfunction

  // Executes one accepted instruction on the model and queues its writeback.
  task automatic model_accept(input logic [31:0] word);
    logic [31:0] a;
    logic [31:0] imm;
    logic [31:0] res;
    logic [4:0]  shamt;
    logic        writes;
    a      = model_regs[word[19:15]];
    imm    = {{20{word[31]}}, word[31:20]};
    shamt  = word[24:20];
    writes = 1'b1;
    res    = '0;
    case (word[6:0])
      OPC_LUI:   res = {word[31:12], 12'h000};
      OPC_AUIPC: res = model_pc + {word[31:12], 12'h000};
      OPC_IMM: begin
        case (word[14:12])
          3'd0: res = a + imm;
          3'd1: res = a << shamt;
          3'd2: res = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
          3'd3: res = (a < imm) ? 32'd1 : 32'd0;
          3'd4: res = a ^ imm;
          3'd5: res = (a >> shamt) | ((word[30] && a[31]) ? ~(32'hFFFF_FFFF >> shamt) : '0);
          3'd6: res = a | imm;
          default: res = a & imm;
        endcase
      end
      default: writes = 1'b0;
    endcase
    if (writes) begin
      exp_q.push_back({word[11:7], res});
      if (word[11:7] != 5'd0) model_regs[word[11:7]] = res;
    end
    model_pc = model_pc + 32'd4;
    accepted++;
  endtask

  task automatic check_writeback();
    logic [36:0] head;
    if (exp_q.size() == 0) begin
      errors++;
      $display("writeback to x%0d at %0t with no instruction outstanding", wb_rd, $time);
    end else begin
      head = exp_q.pop_front();
      rd_a: assert (wb_rd == head[36:32]) else begin
        errors++;
        $display("mismatch at %0t: wb_rd_o got %0d expected %0d", $time, wb_rd, head[36:32]);
      end
      data_a: assert (wb_data == head[31:0]) else begin
        errors++;
        $display("mismatch at %0t: wb_data_o got %h expected %h", $time, wb_data, head[31:0]);
      end
    end
  endtask

  // Inputs are stable by the falling edge, so transfers are observed there.
  always @(negedge clk) begin
    if (rst_n) begin
      count_a: assert (insn_count == accepted) else begin
        errors++;
        $display("mismatch at %0t: insn_count_o got %0d expected %0d", $time, insn_count,
                 accepted);
      end
      if (wb_valid && wb_ready) check_writeback();
      if (instr_valid && instr_ready) model_accept(instr);
    end
  end

  always @(posedge clk) begin
    #2;
    if (ready_random) wb_ready = ($urandom_range(0, 1) == 1);
    else wb_ready = 1'b1;
  end

  task automatic send_instr(input logic [31:0] word);
    int   waited;
    logic taken;
    waited = 0;
    taken  = 1'b0;
    if (timeouts == 0) begin
      instr_valid = 1'b1;
      instr       = word;
      while (!taken && (waited < WAIT_LIMIT)) begin
        @(negedge clk);
        taken = instr_ready;
        @(posedge clk);
        #2;
        waited++;
      end
      instr_valid = 1'b0;
      if (!taken) begin
        timeouts++;
        $display("timeout: instruction %h was never accepted", word);
      end
    end
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (((exp_q.size() != 0) || wb_valid) && (waited < WAIT_LIMIT)) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if ((exp_q.size() != 0) || wb_valid) begin
      timeouts++;
      $display("timeout: %0d writebacks never arrived", exp_q.size());
    end
  endtask

  initial begin
    int          waited;
    logic [4:0]  prev;
    logic [4:0]  rd;
    instr_valid = 1'b0;
    instr       = '0;
    wb_ready    = 1'b1;
    waited      = 0;
    void'($urandom(32'h4769));
    for (int r = 0; r < `RVGA_NREGS; r++) model_regs[r] = '0;
    while ((rst_n !== 1'b1) && (waited < WAIT_LIMIT)) begin
      @(posedge clk);
      waited++;
    end
    #2;
    if (rst_n !== 1'b1) begin
      timeouts++;
      $display("timeout: reset was never released");
    end
    send_instr(make_upper(OPC_LUI, 5'd0, $urandom)); // x0 write still reaches the stream.
    for (int r = 1; r < `RVGA_NREGS; r++) begin
      send_instr(make_upper(OPC_LUI, 5'(r), $urandom));
      send_instr(make_opimm(3'd6, 5'(r), 5'(r), $urandom, 1'b0));
    end
    send_instr(make_opimm(3'd0, 5'd1, 5'd0, $urandom, 1'b0)); // x0 must still read zero.
    for (int k = 0; k < 6; k++) send_instr(make_upper(OPC_AUIPC, 5'($urandom), $urandom));
    for (int f = 0; f < 8; f++) begin
      for (int k = 0; k < 8; k++) begin
        send_instr(make_opimm(3'(f), 5'($urandom), 5'($urandom), $urandom, 1'(k)));
      end
    end
    wait_drained();
    for (int c = 0; c < 6; c++) begin
      prev = 5'($urandom_range(1, 31));
      for (int k = 0; k < 8; k++) begin
        rd = 5'($urandom_range(1, 31));
        send_instr(make_opimm(3'($urandom), rd, prev, $urandom, 1'($urandom)));
        prev = rd;
      end
    end
    wait_drained();
    ready_random = 1'b1;
    for (int k = 0; k < 150; k++) send_instr(random_instr());
    ready_random = 1'b0;
    wait_drained();
    for (int k = 0; k < 4; k++) begin
      send_instr(make_unsupported($urandom));
      send_instr(make_upper(OPC_AUIPC, 5'($urandom_range(1, 31)), $urandom));
    end
    wait_drained();
    @(posedge clk);
    #2;
    $display("closing: %0d check errors, %0d timeouts, %0d instructions", errors, timeouts,
             accepted);
    if ((errors == 0) && (timeouts == 0)) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule : rvga_core_tb

`default_nettype wire

// ==== verification/tb_clkgen.sv ====
`default_nettype none

module tb_clkgen (
  output logic clk,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk     = 1'b0;
    rst_n_o = 1'b0;
    repeat (4) @(posedge clk);
    #2 rst_n_o = 1'b1; // Released just after the fourth rising edge.
  end

  always #20 clk = ~clk;

endmodule : tb_clkgen

`default_nettype wire
